// File: all.f
+incdir+hdl
hdl/instr_pkg.sv
hdl/track_pkg.sv
hdl/issue_queue.sv
hdl/score_board.sv
hdl/register_file.sv
hdl/issue_select.sv
hdl/exec_pipe.sv
hdl/issue_core_top.sv
testbench/tb_clock_gen.sv
testbench/tb_issue_core.sv

// File: hdl/exec_pipe.sv
`default_nettype none

`include "issue_settings.svh"

module exec_pipe (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            flash,
    input  logic                            stall,
    input  logic [1:0]                      lane_valid,
    input  instr_pkg::alu_op_e [1:0]        lane_op,
    input  instr_pkg::reg_data_t [1:0]      lane_a,
    input  instr_pkg::reg_data_t [1:0]      lane_b,
    input  instr_pkg::reg_addr_t [1:0]      lane_dst,
    input  logic [1:0]                      lane_wr,
    output instr_pkg::reg_data_t [1:0][1:0] tap_data,
    output logic [1:0]                      wb_en,
    output instr_pkg::reg_addr_t [1:0]      wb_addr,
    output instr_pkg::reg_data_t [1:0]      wb_data
);
    import instr_pkg::*;

    localparam int half = `DATA_WIDTH / 2;

    logic [1:0]             s1_valid, s2_valid, s3_valid;
    logic [1:0]             s1_wr, s2_wr, s3_wr, s2_mul;
    alu_op_e [1:0]          s1_op;
    reg_addr_t [1:0]        s1_dst, s2_dst, s3_dst;
    reg_data_t [1:0]        s1_a, s1_b, s2_res, s3_res;
    reg_data_t [1:0]        fast_res, s2_sum;
    logic [1:0][half-1:0]   mul_hi, s2_hi;

    // stage 1: fast ops, or the two partial products of a mul
    always_comb begin
        for (int l = 0; l < 2; l++) begin
            mul_hi[l] = s1_a[l][half-1:0] * s1_b[l][`DATA_WIDTH-1:half];
            case (s1_op[l])
                op_add:  fast_res[l] = s1_a[l] + s1_b[l];
                op_sub:  fast_res[l] = s1_a[l] - s1_b[l];
                op_and:  fast_res[l] = s1_a[l] & s1_b[l];
                op_or:   fast_res[l] = s1_a[l] | s1_b[l];
                op_xor:  fast_res[l] = s1_a[l] ^ s1_b[l];
                default: fast_res[l] = s1_a[l] * s1_b[l][half-1:0];  // low partial
            endcase
        end
    end

    // stage 2 finishes the product, low half kept
    always_comb begin
        for (int l = 0; l < 2; l++) begin
            s2_sum[l]      = s2_mul[l] ? s2_res[l] + {s2_hi[l], half'(0)} : s2_res[l];
            tap_data[l][0] = s2_res[l];
            tap_data[l][1] = s3_res[l];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= '0;
            s2_valid <= '0;
            s3_valid <= '0;
        end else if (flash) begin
            s1_valid <= '0;
            s2_valid <= '0;
            s3_valid <= '0;
        end else if (!stall) begin
            s1_valid <= lane_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_op  <= lane_op;
            s1_a   <= lane_a;
            s1_b   <= lane_b;
            s1_dst <= lane_dst;
            s1_wr  <= lane_wr;
            s2_res <= fast_res;
            s2_hi  <= mul_hi;
            s2_mul <= {s1_op[1] == op_mul, s1_op[0] == op_mul};
            s2_dst <= s1_dst;
            s2_wr  <= s1_wr;
            s3_res <= s2_sum;
            s3_dst <= s2_dst;
            s3_wr  <= s2_wr;
        end
    end

    assign wb_en   = stall ? 2'b00 : (s3_valid & s3_wr);
    assign wb_addr = s3_dst;
    assign wb_data = s3_res;

endmodule

`default_nettype wire

// File: hdl/instr_pkg.sv
`default_nettype none

`include "issue_settings.svh"

package instr_pkg;

    typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;
    typedef logic [`DATA_WIDTH-1:0] reg_data_t;
    typedef logic [15:0] imm_t;  // sign-extended at issue

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_mul  // the only slow op
    } alu_op_e;

    // 0..2 instructions per cycle
    typedef logic [1:0] iq_count_t;

endpackage

`default_nettype wire

// File: hdl/issue_core_top.sv
`default_nettype none

module issue_core_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flash,
    input  logic                       stall,
    input  logic                       push,
    input  instr_pkg::reg_addr_t       in_dst,
    input  instr_pkg::reg_addr_t       in_src1,
    input  instr_pkg::reg_addr_t       in_src2,
    input  logic                       in_use_imm,
    input  instr_pkg::imm_t            in_imm,
    input  instr_pkg::alu_op_e         in_op,
    input  logic                       in_wr_en,
    output logic                       full,
    output logic [1:0]                 wb_en,
    output instr_pkg::reg_addr_t [1:0] wb_addr,
    output instr_pkg::reg_data_t [1:0] wb_data
);
    import instr_pkg::*;
    import track_pkg::*;

    iq_count_t              iq_size, pop_count;
    reg_addr_t [1:0]        head_dst, head_src1, head_src2;
    logic [1:0]             head_use_imm, head_wr_en;
    imm_t [1:0]             head_imm;
    alu_op_e [1:0]          head_op;
    reg_addr_t [3:0]        rf_addr, sb_rd_addr;
    reg_data_t [3:0]        rf_data;
    stage_pos_t [3:0]       sb_pos;
    accept_mask_t [3:0]     sb_mask;
    lane_t [3:0]            sb_lane;
    logic [1:0]             sb_wr_en;
    reg_addr_t [1:0]        sb_wr_addr;
    accept_mask_t [1:0]     sb_wr_mask;
    lane_t [1:0]            sb_wr_lane;
    logic [1:0]             lane_valid, lane_wr;
    alu_op_e [1:0]          lane_op;
    reg_data_t [1:0]        lane_a, lane_b;
    reg_addr_t [1:0]        lane_dst;
    reg_data_t [1:0][1:0]   tap_data;

    issue_queue u_queue (.*);

    issue_select u_select (.*);

    score_board u_score_board (
        .clk     (clk),
        .rst_n   (rst_n),
        .flash   (flash),
        .stall   (stall),
        .wr_en   (sb_wr_en),
        .wr_addr (sb_wr_addr),
        .wr_mask (sb_wr_mask),
        .wr_lane (sb_wr_lane),
        .rd_addr (sb_rd_addr),
        .rd_pos  (sb_pos),
        .rd_mask (sb_mask),
        .rd_lane (sb_lane)
    );

    register_file u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_addr (rf_addr),
        .wr_en   (wb_en),
        .wr_addr (wb_addr),
        .wr_data (wb_data),
        .rd_data (rf_data)
    );

    exec_pipe u_exec (.*);

endmodule

`default_nettype wire

// File: hdl/issue_queue.sv
`default_nettype none

`include "issue_settings.svh"

module issue_queue (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flash,
    input  logic                       stall,
    input  logic                       push,
    input  instr_pkg::reg_addr_t       in_dst,
    input  instr_pkg::reg_addr_t       in_src1,
    input  instr_pkg::reg_addr_t       in_src2,
    input  logic                       in_use_imm,
    input  instr_pkg::imm_t            in_imm,
    input  instr_pkg::alu_op_e         in_op,
    input  logic                       in_wr_en,
    input  instr_pkg::iq_count_t       pop_count,
    output logic                       full,
    output instr_pkg::iq_count_t       iq_size,
    output instr_pkg::reg_addr_t [1:0] head_dst,
    output instr_pkg::reg_addr_t [1:0] head_src1,
    output instr_pkg::reg_addr_t [1:0] head_src2,
    output logic [1:0]                 head_use_imm,
    output instr_pkg::imm_t [1:0]      head_imm,
    output instr_pkg::alu_op_e [1:0]   head_op,
    output logic [1:0]                 head_wr_en
);
    import instr_pkg::*;

    localparam int ptr_w = $clog2(`IQ_DEPTH);

    logic [ptr_w-1:0] rd_ptr, wr_ptr;
    logic [ptr_w:0]   count;
    logic             push_ok;
    iq_count_t        pop_eff;

    reg_addr_t dst_q     [`IQ_DEPTH];
    reg_addr_t src1_q    [`IQ_DEPTH];
    reg_addr_t src2_q    [`IQ_DEPTH];
    logic      use_imm_q [`IQ_DEPTH];
    imm_t      imm_q     [`IQ_DEPTH];
    alu_op_e   op_q      [`IQ_DEPTH];
    logic      wr_en_q   [`IQ_DEPTH];

    assign full    = (count == `IQ_DEPTH);
    assign push_ok = push && !full;
    assign pop_eff = stall ? 2'd0 : pop_count;  // pushes still land while stalled
    assign iq_size = (count >= 2) ? 2'd2 : iq_count_t'(count);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flash) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + ptr_w'(push_ok);
            rd_ptr <= rd_ptr + ptr_w'(pop_eff);
            count  <= count + (ptr_w+1)'(push_ok) - (ptr_w+1)'(pop_eff);
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            dst_q[wr_ptr]     <= in_dst;
            src1_q[wr_ptr]    <= in_src1;
            src2_q[wr_ptr]    <= in_src2;
            use_imm_q[wr_ptr] <= in_use_imm;
            imm_q[wr_ptr]     <= in_imm;
            op_q[wr_ptr]      <= in_op;
            wr_en_q[wr_ptr]   <= in_wr_en;
        end
    end

    // oldest two entries
    always_comb begin
        logic [ptr_w-1:0] idx;
        for (int h = 0; h < 2; h++) begin
            idx             = rd_ptr + ptr_w'(h);
            head_dst[h]     = dst_q[idx];
            head_src1[h]    = src1_q[idx];
            head_src2[h]    = src2_q[idx];
            head_use_imm[h] = use_imm_q[idx];
            head_imm[h]     = imm_q[idx];
            head_op[h]      = op_q[idx];
            head_wr_en[h]   = wr_en_q[idx];
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("push into full issue queue");

    a_pop_le_size: assert property (@(posedge clk) disable iff (!rst_n) pop_count <= iq_size)
        else $error("pop beyond valid entries");

endmodule

`default_nettype wire

// File: hdl/issue_select.sv
`default_nettype none

module issue_select (
    input  instr_pkg::iq_count_t            iq_size,
    input  instr_pkg::reg_addr_t [1:0]      head_dst,
    input  instr_pkg::reg_addr_t [1:0]      head_src1,
    input  instr_pkg::reg_addr_t [1:0]      head_src2,
    input  logic [1:0]                      head_use_imm,
    input  instr_pkg::imm_t [1:0]           head_imm,
    input  instr_pkg::alu_op_e [1:0]        head_op,
    input  logic [1:0]                      head_wr_en,
    input  instr_pkg::reg_data_t [3:0]      rf_data,
    input  track_pkg::stage_pos_t [3:0]     sb_pos,
    input  track_pkg::accept_mask_t [3:0]   sb_mask,
    input  track_pkg::lane_t [3:0]          sb_lane,
    input  instr_pkg::reg_data_t [1:0][1:0] tap_data,
    input  logic                            stall,
    output instr_pkg::iq_count_t            pop_count,
    output instr_pkg::reg_addr_t [3:0]      rf_addr,
    output instr_pkg::reg_addr_t [3:0]      sb_rd_addr,
    output logic [1:0]                      sb_wr_en,
    output instr_pkg::reg_addr_t [1:0]      sb_wr_addr,
    output track_pkg::accept_mask_t [1:0]   sb_wr_mask,
    output track_pkg::lane_t [1:0]          sb_wr_lane,
    output logic [1:0]                      lane_valid,
    output instr_pkg::alu_op_e [1:0]        lane_op,
    output instr_pkg::reg_data_t [1:0]      lane_a,
    output instr_pkg::reg_data_t [1:0]      lane_b,
    output instr_pkg::reg_addr_t [1:0]      lane_dst,
    output logic [1:0]                      lane_wr
);
    import instr_pkg::*;
    import track_pkg::*;

    logic [3:0]      reg_ok;
    reg_data_t [3:0] reg_val;
    logic [1:0]      ready;
    logic            pair_dep;

    // src1/src2 of head 0, then of head 1
    assign rf_addr    = {head_src2[1], head_src1[1], head_src2[0], head_src1[0]};
    assign sb_rd_addr = rf_addr;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            reg_ok[i]  = 1'b0;
            reg_val[i] = rf_data[i];
            if (sb_pos[i] == '0) begin
                reg_ok[i] = 1'b1;
            end else if ((sb_pos[i] & sb_mask[i]) != '0) begin
                reg_ok[i]  = 1'b1;
                reg_val[i] = tap_data[sb_lane[i]][sb_pos[i][0]];  // 010 stage 2, 001 stage 3
            end
        end
    end

    always_comb begin
        for (int h = 0; h < 2; h++) begin
            ready[h]  = reg_ok[2*h] && (head_use_imm[h] || reg_ok[2*h+1]);
            lane_a[h] = reg_val[2*h];
            lane_b[h] = head_use_imm[h] ? reg_data_t'($signed(head_imm[h])) : reg_val[2*h+1];
        end
    end

    // no bypass inside a pair, the younger one waits
    assign pair_dep = head_wr_en[0] && (head_dst[0] != '0) &&
                      ((head_src1[1] == head_dst[0]) ||
                       (!head_use_imm[1] && head_src2[1] == head_dst[0]));

    always_comb begin
        if (stall || iq_size == 2'd0 || !ready[0]) begin
            pop_count = 2'd0;
        end else if (iq_size == 2'd1 || !ready[1] || pair_dep) begin
            pop_count = 2'd1;
        end else begin
            pop_count = 2'd2;
        end
    end

    assign lane_valid = {pop_count == 2'd2, pop_count != 2'd0};
    assign lane_op    = head_op;
    assign lane_dst   = head_dst;
    assign lane_wr    = head_wr_en;

    always_comb begin
        for (int h = 0; h < 2; h++) begin
            sb_wr_en[h]   = lane_valid[h] && head_wr_en[h] && (head_dst[h] != '0);
            sb_wr_mask[h] = (head_op[h] == op_mul) ? mask_mul : mask_fast;
            sb_wr_lane[h] = lane_t'(h);
        end
    end

    assign sb_wr_addr = head_dst;

endmodule

`default_nettype wire

// File: hdl/issue_settings.svh
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// architectural registers
`define REG_COUNT 32

`define DATA_WIDTH 32

// issue queue entries
`define IQ_DEPTH 4

// execution stages, also the width of a stage position
`define PIPE_DEPTH 3

`endif

// File: hdl/register_file.sv
`default_nettype none

`include "issue_settings.svh"

module register_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  instr_pkg::reg_addr_t [3:0] rd_addr,
    input  logic [1:0]                 wr_en,
    input  instr_pkg::reg_addr_t [1:0] wr_addr,
    input  instr_pkg::reg_data_t [1:0] wr_data,
    output instr_pkg::reg_data_t [3:0] rd_data
);
    import instr_pkg::*;

    reg_data_t regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w] && wr_addr[w] != '0) begin  // r0 stays zero
                    regs[wr_addr[w]] <= wr_data[w];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rd_data[i] = regs[rd_addr[i]];
        end
    end

endmodule

`default_nettype wire

// File: hdl/score_board.sv
`default_nettype none

`include "issue_settings.svh"

module score_board (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flash,
    input  logic                          stall,
    input  logic [1:0]                    wr_en,
    input  instr_pkg::reg_addr_t [1:0]    wr_addr,
    input  track_pkg::accept_mask_t [1:0] wr_mask,
    input  track_pkg::lane_t [1:0]        wr_lane,
    input  instr_pkg::reg_addr_t [3:0]    rd_addr,
    output track_pkg::stage_pos_t [3:0]   rd_pos,
    output track_pkg::accept_mask_t [3:0] rd_mask,
    output track_pkg::lane_t [3:0]        rd_lane
);
    import track_pkg::*;

    stage_pos_t   pos_q  [`REG_COUNT];
    accept_mask_t mask_q [`REG_COUNT];
    lane_t        lane_q [`REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                pos_q[r] <= '0;
            end
        end else if (flash) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                pos_q[r] <= '0;
            end
        end else if (!stall) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                pos_q[r] <= pos_q[r] >> 1;  // follows the pipeline
            end
            // lane 1 is younger, its write lands last
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w] && wr_addr[w] != '0) begin
                    pos_q[wr_addr[w]] <= pos_issue;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w]) begin
                    mask_q[wr_addr[w]] <= wr_mask[w];
                    lane_q[wr_addr[w]] <= wr_lane[w];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rd_pos[i]  = (rd_addr[i] == '0) ? '0 : pos_q[rd_addr[i]];  // r0 never pending
            rd_mask[i] = mask_q[rd_addr[i]];
            rd_lane[i] = lane_q[rd_addr[i]];
        end
    end

    for (genvar r = 1; r < `REG_COUNT; r++) begin : g_pos_chk
        a_pos_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pos_q[r]))
            else $error("scoreboard position of r%0d not one-hot", r);
    end

endmodule

`default_nettype wire

// File: hdl/track_pkg.sv
`default_nettype none

`include "issue_settings.svh"

package track_pkg;

    // one-hot, msb is stage 1, zero means the value sits in the register file
    typedef logic [`PIPE_DEPTH-1:0] stage_pos_t;
    typedef logic [`PIPE_DEPTH-1:0] accept_mask_t;
    typedef logic lane_t;

    localparam stage_pos_t pos_issue = stage_pos_t'(1) << (`PIPE_DEPTH - 1);

    localparam accept_mask_t mask_fast = 3'b011;  // bypass from stage 2 on
    localparam accept_mask_t mask_mul  = 3'b001;  // stage 3 only

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the issue core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -j 0 -f all.f --top-module tb_issue_core -o tb_issue_core \
    && ./obj_dir/tb_issue_core > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "\*\*\* PASSED \*\*\*" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int half_period = 50;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // low for three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_issue_core.sv
`default_nettype none

`include "issue_settings.svh"

module tb_issue_core;
    import instr_pkg::*;

    localparam int n_rows      = 6;
    localparam int n_instr     = 35;
    localparam int cycle_limit = 20 * n_instr + 200;

    typedef struct packed {
        alu_op_e   op;
        reg_addr_t dst;
        reg_addr_t src1;
        reg_addr_t src2;
        logic      use_imm;  // replaces src2
    } instr_t;

    logic            clk, rst_n, flash, stall, push, full;
    reg_addr_t       in_dst, in_src1, in_src2;
    logic            in_use_imm, in_wr_en;
    imm_t            in_imm;
    alu_op_e         in_op;
    logic [1:0]      wb_en;
    reg_addr_t [1:0] wb_addr;
    reg_data_t [1:0] wb_data;

    // op, dst, src1, src2, use_imm
    instr_t prog [n_instr] = '{
        '{op_add, 5'd1, 5'd0, 5'd0, 1'b1}, '{op_xor, 5'd2, 5'd0, 5'd0, 1'b1},
        '{op_or, 5'd3, 5'd0, 5'd0, 1'b1}, '{op_add, 5'd4, 5'd0, 5'd0, 1'b1},
        '{op_sub, 5'd5, 5'd0, 5'd0, 1'b1}, '{op_or, 5'd6, 5'd0, 5'd0, 1'b1},
        '{op_add, 5'd7, 5'd1, 5'd2, 1'b0}, '{op_add, 5'd8, 5'd7, 5'd0, 1'b1},
        '{op_and, 5'd9, 5'd8, 5'd3, 1'b0}, '{op_xor, 5'd10, 5'd9, 5'd4, 1'b0},
        '{op_or, 5'd11, 5'd10, 5'd7, 1'b0}, '{op_add, 5'd12, 5'd11, 5'd11, 1'b0},
        '{op_mul, 5'd13, 5'd1, 5'd2, 1'b0}, '{op_add, 5'd14, 5'd13, 5'd0, 1'b1},
        '{op_mul, 5'd15, 5'd14, 5'd3, 1'b0}, '{op_sub, 5'd16, 5'd15, 5'd13, 1'b0},
        '{op_mul, 5'd17, 5'd16, 5'd0, 1'b1}, '{op_xor, 5'd18, 5'd17, 5'd1, 1'b0},
        '{op_add, 5'd19, 5'd5, 5'd0, 1'b1}, '{op_sub, 5'd20, 5'd19, 5'd6, 1'b0},
        '{op_add, 5'd0, 5'd1, 5'd2, 1'b0}, '{op_or, 5'd21, 5'd0, 5'd19, 1'b0},
        '{op_xor, 5'd22, 5'd21, 5'd20, 1'b0}, '{op_add, 5'd23, 5'd0, 5'd0, 1'b1},
        '{op_add, 5'd24, 5'd7, 5'd0, 1'b1}, '{op_mul, 5'd25, 5'd24, 5'd8, 1'b0},
        '{op_add, 5'd26, 5'd25, 5'd24, 1'b0}, '{op_sub, 5'd27, 5'd26, 5'd0, 1'b1},
        '{op_xor, 5'd28, 5'd27, 5'd25, 1'b0},
        '{op_add, 5'd29, 5'd9, 5'd0, 1'b1}, '{op_xor, 5'd30, 5'd29, 5'd10, 1'b0},
        '{op_add, 5'd29, 5'd0, 5'd0, 1'b1}, '{op_mul, 5'd30, 5'd29, 5'd2, 1'b0},
        '{op_add, 5'd31, 5'd29, 5'd30, 1'b0}, '{op_sub, 5'd1, 5'd31, 5'd0, 1'b1}
    };

    string row_name [n_rows] = '{"independent_pairs", "bypass_chain", "mul_consumer",
                                 "pair_dependence", "stall_hold", "flash_discard"};
    int        row_len   [n_rows] = '{6, 6, 6, 6, 5, 6};
    int        stall_at  [n_rows] = '{0, -1, -1, 0, 3, -1};
    int        stall_len [n_rows] = '{4, 0, 0, 4, 5, 0};
    int        flash_at  [n_rows] = '{-1, -1, -1, -1, -1, 2};  // first of two dropped
    // expected writeback distance in cycles from producer to consumer
    reg_addr_t gap_prod  [n_rows] = '{5'd1, 5'd11, 5'd17, 5'd19, 5'd0, 5'd0};
    reg_addr_t gap_cons  [n_rows] = '{5'd2, 5'd12, 5'd18, 5'd20, 5'd0, 5'd0};
    int        gap_min   [n_rows] = '{0, 2, 3, 2, 0, 0};
    int        gap_max   [n_rows] = '{0, 2, 3, 2, 0, 0};

    reg_data_t   model_regs [`REG_COUNT];
    int          wb_cycle   [`REG_COUNT];
    reg_addr_t   exp_dst [$];
    reg_data_t   exp_val [$];
    logic [31:0] lcg_state;
    string       cur_name;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    tb_clock_gen i_clock (.clk(clk), .rst_n(rst_n));

    issue_core_top i_dut (.*);

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic reg_data_t alu_ref(input alu_op_e op, input reg_data_t a,
                                          input reg_data_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            default: return a * b;  // low word
        endcase
    endfunction

    task automatic wait_slot();
        @(posedge clk);
        #10;
    endtask

    task automatic drive_instr(input instr_t ins, input logic use_model);
        logic [31:0] rnd;
        imm_t        imm;
        reg_data_t   b;
        reg_data_t   res;
        rnd        = next_rand();
        imm        = imm_t'(rnd >> 16);
        push       = 1'b1;
        in_op      = ins.op;
        in_dst     = ins.dst;
        in_src1    = ins.src1;
        in_src2    = ins.src2;
        in_use_imm = ins.use_imm;
        in_imm     = imm;
        in_wr_en   = 1'b1;
        if (use_model) begin
            b   = ins.use_imm ? {{16{imm[15]}}, imm} : model_regs[ins.src2];
            res = alu_ref(ins.op, model_regs[ins.src1], b);
            exp_dst.push_back(ins.dst);
            exp_val.push_back(res);
            if (ins.dst != '0) model_regs[ins.dst] = res;
        end
    endtask

    task automatic drain();
        push  = 1'b0;
        stall = 1'b0;
        while (exp_dst.size() != 0) wait_slot();
        repeat (2) wait_slot();
    endtask

    // two instructions go in behind an idle pipe
    // flash hits the first in flight and the second still queued on it
    task automatic discard_pair(input int k);
        drain();
        for (int d = 0; d < 2; d++) begin
            drive_instr(prog[k + d], 1'b0);
            wait_slot();
        end
        push  = 1'b0;
        flash = 1'b1;
        wait_slot();
        flash = 1'b0;
    endtask

    task automatic check_wb(input reg_addr_t addr, input reg_data_t data);
        int idx;
        idx = -1;
        for (int k = 0; k < exp_dst.size(); k++) begin
            if (idx < 0 && exp_dst[k] == addr) idx = k;
        end
        checks++;
        assert (idx >= 0) else begin
            $display("unexpected writeback to r%0d in %s", addr, cur_name);
            errors++;
        end
        if (idx >= 0) begin
            assert (data == exp_val[idx]) else begin
                $display("MISMATCH %s r%0d expected %h actual %h",
                         cur_name, addr, exp_val[idx], data);
                errors++;
            end
            exp_dst.delete(idx);
            exp_val.delete(idx);
            wb_cycle[addr] = cycles;
        end
    endtask

    task automatic run_row(input int r, input int base);
        int i;
        int slot;
        int stall_end;
        int gap;
        i         = 0;
        slot      = 0;
        stall_end = stall_at[r] + stall_len[r];
        cur_name  = row_name[r];
        while (i < row_len[r] || slot < stall_end) begin
            if (i == flash_at[r]) begin
                discard_pair(base + i);
                i += 2;
            end else begin
                // queue starts the row empty and nothing pops under stall
                if (stall_at[r] == 0 && slot <= stall_end) begin
                    checks++;
                    assert (full == (i >= `IQ_DEPTH)) else begin
                        $display("MISMATCH %s full expected %0d actual %0d",
                                 cur_name, i >= `IQ_DEPTH, full);
                        errors++;
                    end
                end
                stall = (slot >= stall_at[r] && slot < stall_end);
                if (i < row_len[r] && !full) begin
                    drive_instr(prog[base + i], 1'b1);
                    i++;
                end else begin
                    push = 1'b0;
                end
                wait_slot();
            end
            slot++;
        end
        drain();
        if (gap_cons[r] != '0) begin
            gap = wb_cycle[gap_cons[r]] - wb_cycle[gap_prod[r]];
            checks++;
            assert (gap >= gap_min[r] && gap <= gap_max[r]) else begin
                $display("MISMATCH %s gap r%0d to r%0d expected %0d..%0d actual %0d",
                         cur_name, gap_prod[r], gap_cons[r], gap_min[r], gap_max[r], gap);
                errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, run went past %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // sampled mid-cycle with lane 0 as the older one
    always @(negedge clk) begin
        if (rst_n) begin
            if (stall) begin
                checks++;
                assert (wb_en == 2'b00) else begin
                    $display("writeback while stalled in %s", cur_name);
                    errors++;
                end
            end
            for (int l = 0; l < 2; l++) begin
                if (wb_en[l]) check_wb(wb_addr[l], wb_data[l]);
            end
        end
    end

    initial begin
        int base;
        push       = 1'b0;
        flash      = 1'b0;
        stall      = 1'b0;
        in_dst     = '0;
        in_src1    = '0;
        in_src2    = '0;
        in_use_imm = 1'b0;
        in_imm     = '0;
        in_op      = op_add;
        in_wr_en   = 1'b0;
        lcg_state  = 32'h2a9a2765;
        for (int r = 0; r < `REG_COUNT; r++) begin
            model_regs[r] = '0;
            wb_cycle[r]   = 0;
        end
        @(posedge rst_n);
        base = 0;
        for (int r = 0; r < n_rows; r++) begin
            run_row(r, base);
            base += row_len[r];
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
